// File: vlog.f
+incdir+common
common/xdom_pkg.sv
common/reg_bus_if.sv
logic/xdom_regs.sv
logic/xdom_rd_mux.sv
logic/io_ctrl_demux.sv
logic/pulser_timer.sv
logic/page_req_fsm.sv
logic/xdom_top.sv
bench/xdom_tb.sv

// File: Bender.yml
package:
  name: xdom_regs

sources:
  - include_dirs:
      - common
    files:
      - common/xdom_pkg.sv
      - common/reg_bus_if.sv
      - logic/xdom_regs.sv
      - logic/xdom_rd_mux.sv
      - logic/io_ctrl_demux.sv
      - logic/pulser_timer.sv
      - logic/page_req_fsm.sv
      - logic/xdom_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/xdom_tb.sv

// File: bench/xdom_tb.sv
/* Testbench for the register block with random register traffic checked against a model
   Also checks strobes, IO pulses, the pulser, the page request and scaler readback */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module xdom_tb;

  localparam int n_ch = `XDOM_N_CHANNELS;

  // Configuration registers that read back what was written
  localparam logic [16:0][11:0] cfg_adr_list = {
    `XDOM_ADR_TRIG_CONF, `XDOM_ADR_TRIG_THR, `XDOM_ADR_SW_MASK_HI, `XDOM_ADR_SW_MASK_LO,
    `XDOM_ADR_ARM_MASK_HI, `XDOM_ADR_ARM_MASK_LO, `XDOM_ADR_IO_SEL,
    `XDOM_ADR_PULSE_MASK_HI, `XDOM_ADR_PULSE_MASK_LO, `XDOM_ADR_PG_ADR_HI,
    `XDOM_ADR_PG_ADR_LO, `XDOM_ADR_PG_OPTYPE, `XDOM_ADR_DDR3_RST, `XDOM_ADR_SCALER_SEL,
    `XDOM_ADR_PULSE_PER_HI, `XDOM_ADR_PULSE_PER_LO, `XDOM_ADR_PULSE_EN
  };

  logic                                     clk = 1'b0;
  logic                                     rst;
  logic [`XDOM_ADR_W-1:0]                   adr;
  logic                                     wr;
  logic [`XDOM_DATA_W-1:0]                  wr_data;
  logic [`XDOM_DATA_W-1:0]                  vnum;
  logic [n_ch-1:0]                          wvb_armed;
  logic [n_ch-1:0][`XDOM_SCALER_W-1:0]      disc_scaler;
  logic                                     pg_ack;
  logic [`XDOM_DATA_W-1:0]                  rd_data;
  logic [`XDOM_DATA_W+11:0]                 trig_bundle;
  logic [n_ch-1:0]                          trig_run;
  logic [n_ch-1:0]                          wvb_arm;
  logic [2*n_ch-1:0]                        adc_delay_ce;
  logic [2*n_ch-1:0]                        adc_delay_inc;
  logic [2*n_ch-1:0]                        adc_bitslip;
  logic [n_ch-1:0]                          discr_bitslip;
  logic [`XDOM_N_PULSERS-1:0]               pulser_trig;
  logic [`XDOM_PG_ADR_W-1:0]                pg_req_addr;
  logic                                     pg_optype;
  logic                                     pg_req;
  logic                                     ddr3_sys_rst;

  integer seed = 32'hdcd0;

  // Register model
  logic [6:0]  m_trig_conf = '0;
  logic [11:0] m_trig_thr = '0;
  logic [23:0] m_sw_mask = '0;
  logic [23:0] m_arm_mask = '0;
  logic [23:0] m_pulse_mask = '0;
  logic [4:0]  m_io_sel = '0;
  logic [4:0]  m_scaler_sel = '0;
  logic [5:0]  m_pulse_en = '0;
  logic [31:0] m_pulse_period = '0;
  logic [27:0] m_pg_addr = '0;
  logic        m_pg_optype = 1'b0;
  logic        m_ddr3_rst = 1'b0;
  logic        m_pg_status = 1'b0;

  always #5 clk = ~clk;

  xdom_top xdom_top_i (
    .clk(clk), .rst(rst), .i_adr(adr), .i_wr(wr), .i_wr_data(wr_data),
    .i_vnum(vnum), .i_wvb_armed(wvb_armed), .i_disc_scaler(disc_scaler),
    .i_pg_ack(pg_ack), .o_rd_data(rd_data), .o_trig_bundle(trig_bundle),
    .o_trig_run(trig_run), .o_wvb_arm(wvb_arm), .o_adc_delay_ce(adc_delay_ce),
    .o_adc_delay_inc(adc_delay_inc), .o_adc_bitslip(adc_bitslip),
    .o_discr_bitslip(discr_bitslip), .o_pulser_trig(pulser_trig),
    .o_pg_req_addr(pg_req_addr), .o_pg_optype(pg_optype), .o_pg_req(pg_req),
    .o_ddr3_sys_rst(ddr3_sys_rst)
  );

  ////////////////////////////////////////////////////////////
  // Checks and bus access

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Error: %s", what);
    $display("=== FAIL ===");
    $fatal(1, "%s", what);
  endtask

  task automatic model_write(input logic [11:0] a, input logic [15:0] d);
    case (a)
      `XDOM_ADR_TRIG_CONF: m_trig_conf = d[6:0];
      `XDOM_ADR_TRIG_THR: m_trig_thr = d[11:0];
      `XDOM_ADR_SW_MASK_HI: m_sw_mask[23:16] = d[7:0];
      `XDOM_ADR_SW_MASK_LO: m_sw_mask[15:0] = d;
      `XDOM_ADR_ARM_MASK_HI: m_arm_mask[23:16] = d[7:0];
      `XDOM_ADR_ARM_MASK_LO: m_arm_mask[15:0] = d;
      `XDOM_ADR_IO_SEL: m_io_sel = d[4:0];
      `XDOM_ADR_PULSE_MASK_HI: m_pulse_mask[23:16] = d[7:0];
      `XDOM_ADR_PULSE_MASK_LO: m_pulse_mask[15:0] = d;
      `XDOM_ADR_PG_ADR_HI: m_pg_addr[27:16] = d[11:0];
      `XDOM_ADR_PG_ADR_LO: m_pg_addr[15:0] = d;
      `XDOM_ADR_PG_OPTYPE: m_pg_optype = d[0];
      `XDOM_ADR_DDR3_RST: m_ddr3_rst = d[0];
      `XDOM_ADR_SCALER_SEL: m_scaler_sel = d[4:0];
      `XDOM_ADR_PULSE_PER_HI: m_pulse_period[31:16] = d;
      `XDOM_ADR_PULSE_PER_LO: m_pulse_period[15:0] = d;
      `XDOM_ADR_PULSE_EN: m_pulse_en = d[5:0];
      default: ;
    endcase
  endtask

  // Strobe registers read zero outside their single active cycle
  function automatic logic [15:0] expected_read(input logic [11:0] a);
    logic [31:0] sc;
    sc = (m_scaler_sel < n_ch) ? disc_scaler[m_scaler_sel] : 32'd0;
    case (a)
      `XDOM_ADR_VNUM: return vnum;
      `XDOM_ADR_TRIG_CONF: return {9'd0, m_trig_conf};
      `XDOM_ADR_TRIG_THR: return {4'd0, m_trig_thr};
      `XDOM_ADR_SW_MASK_HI: return {8'd0, m_sw_mask[23:16]};
      `XDOM_ADR_SW_MASK_LO: return m_sw_mask[15:0];
      `XDOM_ADR_ARM_MASK_HI: return {8'd0, m_arm_mask[23:16]};
      `XDOM_ADR_ARM_MASK_LO: return m_arm_mask[15:0];
      `XDOM_ADR_ARMED_HI: return {8'd0, wvb_armed[23:16]};
      `XDOM_ADR_ARMED_LO: return wvb_armed[15:0];
      `XDOM_ADR_IO_SEL: return {11'd0, m_io_sel};
      `XDOM_ADR_PULSE_MASK_HI: return {8'd0, m_pulse_mask[23:16]};
      `XDOM_ADR_PULSE_MASK_LO: return m_pulse_mask[15:0];
      `XDOM_ADR_PG_ADR_HI: return {4'd0, m_pg_addr[27:16]};
      `XDOM_ADR_PG_ADR_LO: return m_pg_addr[15:0];
      `XDOM_ADR_PG_OPTYPE: return {15'd0, m_pg_optype};
      `XDOM_ADR_PG_CMD: return {15'd0, m_pg_status};
      `XDOM_ADR_DDR3_RST: return {15'd0, m_ddr3_rst};
      `XDOM_ADR_SCALER_SEL: return {11'd0, m_scaler_sel};
      `XDOM_ADR_SCALER_HI: return sc[31:16];
      `XDOM_ADR_SCALER_LO: return sc[15:0];
      `XDOM_ADR_PULSE_PER_HI: return m_pulse_period[31:16];
      `XDOM_ADR_PULSE_PER_LO: return m_pulse_period[15:0];
      `XDOM_ADR_PULSE_EN: return {10'd0, m_pulse_en};
      default: return 16'd0;
    endcase
  endfunction

  // Returns at the falling edge of the cycle right after the write lands
  task automatic write_reg(input logic [11:0] a, input logic [15:0] d);
    @(posedge clk);
    adr     <= a;
    wr      <= 1'b1;
    wr_data <= d;
    @(posedge clk);
    wr <= 1'b0;
    model_write(a, d);
    @(negedge clk);
  endtask

  task automatic read_reg(input logic [11:0] a, output logic [15:0] d);
    @(posedge clk);
    adr <= a;
    @(negedge clk);
    d = rd_data;
  endtask

  task automatic read_check(input logic [11:0] a);
    logic [15:0] d;
    read_reg(a, d);
    check_equal($sformatf("o_rd_data at %h", a), d, expected_read(a));
  endtask

  task automatic check_strobes_idle();
    check_equal("o_trig_run", trig_run, 0);
    check_equal("o_wvb_arm", wvb_arm, 0);
    check_equal("o_pulser_trig", pulser_trig, 0);
  endtask

  task automatic check_io_pulses(input int sel, input logic [15:0] d);
    logic [47:0] ce;
    logic [47:0] inc;
    logic [47:0] slip;
    logic [23:0] disc;
    ce = '0;
    inc = '0;
    slip = '0;
    disc = '0;
    ce[2*sel +: 2] = {d[5], d[1]};
    inc[2*sel +: 2] = {d[4], d[0]};
    slip[2*sel +: 2] = {d[6], d[2]};
    disc[sel] = d[8];
    check_equal("o_adc_delay_ce", adc_delay_ce, ce);
    check_equal("o_adc_delay_inc", adc_delay_inc, inc);
    check_equal("o_adc_bitslip", adc_bitslip, slip);
    check_equal("o_discr_bitslip", discr_bitslip, disc);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [11:0] a;
    logic [15:0] d;
    logic [5:0]  en;
    int          sel;
    int          per;
    int          wait_cycles;
    rst = 1'b1;
    adr = '0;
    wr = 1'b0;
    wr_data = '0;
    pg_ack = 1'b0;
    vnum = $random(seed);
    wvb_armed = $random(seed);
    for (int ch = 0; ch < n_ch; ch++) begin
      disc_scaler[ch] = $random(seed);
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_strobes_idle();
    check_equal("o_pg_req", pg_req, 0);
    check_equal("o_ddr3_sys_rst", ddr3_sys_rst, 0);
    check_equal("o_trig_bundle", trig_bundle, 0);

    // Register readback, version number and unmapped addresses
    for (int i = 0; i < 200; i++) begin
      a = cfg_adr_list[$unsigned($random(seed)) % 17];
      write_reg(a, $random(seed));
      read_check(a);
      read_check($random(seed));
    end
    read_check(`XDOM_ADR_VNUM);
    read_check(`XDOM_ADR_ARMED_HI);
    read_check(`XDOM_ADR_ARMED_LO);
    read_check(12'h000);
    read_check(12'hbf7);
    check_equal("o_trig_bundle", trig_bundle, {m_trig_thr, 9'd0, m_trig_conf});
    check_equal("o_pg_req_addr", pg_req_addr, m_pg_addr);
    check_equal("o_pg_optype", pg_optype, m_pg_optype);
    check_equal("o_ddr3_sys_rst", ddr3_sys_rst, m_ddr3_rst);
    write_reg(`XDOM_ADR_PULSE_PER_HI, 16'd0);
    write_reg(`XDOM_ADR_PULSE_PER_LO, 16'd0);
    write_reg(`XDOM_ADR_PULSE_EN, 16'd0);

    // Trigger, arm and single-shot strobes
    check_strobes_idle();
    for (int i = 0; i < 20; i++) begin
      d = $random(seed);
      if (i % 2 == 0) begin
        write_reg(`XDOM_ADR_TRIG_CMD, d);
        check_equal("o_trig_run", trig_run, d[0] ? m_sw_mask : 24'd0);
        check_equal("o_wvb_arm", wvb_arm, d[1] ? m_arm_mask : 24'd0);
        check_equal("o_pulser_trig", pulser_trig, 0);
      end else begin
        write_reg(`XDOM_ADR_PULSE_SINGLE, d);
        check_equal("o_pulser_trig", pulser_trig, d[5:0]);
        check_equal("o_trig_run", trig_run, m_pulse_mask);
        check_equal("o_wvb_arm", wvb_arm, 0);
      end
      @(negedge clk);
      check_strobes_idle();
    end

    // IO alignment pulses land two cycles after the command write
    for (int i = 0; i < 20; i++) begin
      sel = $unsigned($random(seed)) % n_ch;
      d = $random(seed);
      write_reg(`XDOM_ADR_IO_SEL, sel);
      write_reg(`XDOM_ADR_IO_CMD, d);
      check_io_pulses(sel, 16'd0);
      @(negedge clk);
      check_io_pulses(sel, d);
      @(negedge clk);
      check_io_pulses(sel, 16'd0);
    end

    // Periodic pulser
    for (int i = 0; i < 6; i++) begin
      per = 2 + $unsigned($random(seed)) % 6;
      en = $random(seed);
      if (en == 6'd0) en = 6'h01;
      write_reg(`XDOM_ADR_PULSE_EN, en);
      write_reg(`XDOM_ADR_PULSE_PER_LO, per);
      wait_cycles = 0;
      while (pulser_trig == 6'd0) begin
        if (wait_cycles > per + 4) abort_run("no periodic pulser output after the period was set");
        @(negedge clk);
        wait_cycles++;
      end
      check_equal("o_pulser_trig", pulser_trig, en);
      for (int k = 1; k <= 3 * per; k++) begin
        @(negedge clk);
        check_equal("o_pulser_trig", pulser_trig, (k % per == 0) ? en : 6'd0);
      end
      write_reg(`XDOM_ADR_PULSE_PER_LO, 16'd0);
      for (int k = 0; k < 24; k++) begin
        @(negedge clk);
        check_equal("o_pulser_trig", pulser_trig, 0);
      end
    end

    // Page request handshake
    write_reg(`XDOM_ADR_DDR3_RST, 16'd1);
    for (int i = 0; i < 6; i++) begin
      write_reg(`XDOM_ADR_PG_CMD, 16'd1);
      check_equal("o_pg_req", pg_req, 0);
      @(negedge clk);
      check_equal("o_pg_req", pg_req, 1);
      m_pg_status = 1'b1;
      read_check(`XDOM_ADR_PG_CMD);
      repeat ($unsigned($random(seed)) % 8) begin
        @(negedge clk);
        check_equal("o_pg_req", pg_req, 1);
      end
      @(posedge clk);
      pg_ack <= 1'b1;
      wait_cycles = 0;
      do begin
        @(negedge clk);
        wait_cycles++;
        if (pg_req && wait_cycles == 4) abort_run("page request stayed high after the acknowledge");
      end while (pg_req);
      read_check(`XDOM_ADR_PG_CMD);
      @(posedge clk);
      pg_ack <= 1'b0;
      m_pg_status = 1'b0;
      wait_cycles = 0;
      do begin
        read_reg(`XDOM_ADR_PG_CMD, d);
        wait_cycles++;
        if (d != 16'd0 && wait_cycles == 6) abort_run("page status did not clear");
      end while (d != 16'd0);
    end
    write_reg(`XDOM_ADR_PG_CMD, 16'd1);
    @(negedge clk);
    check_equal("o_pg_req", pg_req, 1);
    write_reg(`XDOM_ADR_DDR3_RST, 16'd0);
    check_equal("o_ddr3_sys_rst", ddr3_sys_rst, 0);
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
      if (pg_req && wait_cycles == 3) abort_run("page request stayed high after DDR3 disable");
    end while (pg_req);
    write_reg(`XDOM_ADR_PG_CMD, 16'd1);
    repeat (8) begin
      @(negedge clk);
      check_equal("o_pg_req", pg_req, 0);
    end
    read_check(`XDOM_ADR_PG_CMD);

    // Scaler readback
    for (int i = 0; i < 16; i++) begin
      sel = $unsigned($random(seed)) % n_ch;
      write_reg(`XDOM_ADR_SCALER_SEL, sel);
      read_check(`XDOM_ADR_SCALER_LO);
      read_check(`XDOM_ADR_SCALER_HI);
      @(posedge clk);
      disc_scaler[sel] <= $random(seed);
      read_check(`XDOM_ADR_SCALER_LO);
      read_check(`XDOM_ADR_SCALER_HI);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/xdom_top.sv
/* Register block top level: plain register-bus ports in, control strobes,
   IO-alignment pulses, pulser triggers and the DDR3 page request out */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module xdom_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [`XDOM_ADR_W-1:0]                        i_adr,
  input  logic                                          i_wr,
  input  logic [`XDOM_DATA_W-1:0]                       i_wr_data,
  input  logic [`XDOM_DATA_W-1:0]                       i_vnum,
  input  logic [`XDOM_N_CHANNELS-1:0]                   i_wvb_armed,
  input  logic [`XDOM_N_CHANNELS-1:0][`XDOM_SCALER_W-1:0] i_disc_scaler,
  input  logic                                          i_pg_ack,
  output logic [`XDOM_DATA_W-1:0]                       o_rd_data,
  output logic [`XDOM_DATA_W+11:0]                      o_trig_bundle,
  output logic [`XDOM_N_CHANNELS-1:0]                   o_trig_run,
  output logic [`XDOM_N_CHANNELS-1:0]                   o_wvb_arm,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_delay_ce,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_delay_inc,
  output logic [2*`XDOM_N_CHANNELS-1:0]                 o_adc_bitslip,
  output logic [`XDOM_N_CHANNELS-1:0]                   o_discr_bitslip,
  output logic [`XDOM_N_PULSERS-1:0]                    o_pulser_trig,
  output logic [`XDOM_PG_ADR_W-1:0]                     o_pg_req_addr,
  output logic                                          o_pg_optype,
  output logic                                          o_pg_req,
  output logic                                          o_ddr3_sys_rst
);

  xdom_pkg::trig_conf_t              trig_conf;
  xdom_pkg::io_cmd_t                 io_cmd;
  logic [11:0]                       trig_thr;
  logic [`XDOM_N_CHANNELS-1:0]       sw_mask;
  logic [`XDOM_N_CHANNELS-1:0]       arm_mask;
  logic [`XDOM_N_CHANNELS-1:0]       pulse_mask;
  logic [`XDOM_SEL_W-1:0]            io_sel;
  logic [`XDOM_SEL_W-1:0]            scaler_sel;
  logic [`XDOM_N_PULSERS-1:0]        pulse_single;
  logic [`XDOM_N_PULSERS-1:0]        pulse_en;
  logic [31:0]                       pulse_period;
  logic                              pg_start;
  logic                              pg_status;

  reg_bus_if bus ();

  assign bus.adr     = i_adr;
  assign bus.wr      = i_wr;
  assign bus.wr_data = i_wr_data;
  assign o_rd_data   = bus.rd_data;

  // Threshold above the configuration word
  assign o_trig_bundle = {trig_thr, trig_conf};

  xdom_regs xdom_regs_i (
    .clk(clk), .rst(rst), .bus(bus),
    .o_trig_conf(trig_conf), .o_trig_thr(trig_thr),
    .o_trig_run(o_trig_run), .o_wvb_arm(o_wvb_arm),
    .o_sw_mask(sw_mask), .o_arm_mask(arm_mask), .o_pulse_mask(pulse_mask),
    .o_io_sel(io_sel), .o_io_cmd(io_cmd),
    .o_pulse_single(pulse_single), .o_pulse_en(pulse_en), .o_pulse_period(pulse_period),
    .o_pg_start(pg_start), .o_pg_addr(o_pg_req_addr), .o_pg_optype(o_pg_optype),
    .o_ddr3_sys_rst(o_ddr3_sys_rst), .o_scaler_sel(scaler_sel)
  );

  xdom_rd_mux xdom_rd_mux_i (
    .clk(clk), .rst(rst), .bus(bus),
    .i_trig_conf(trig_conf), .i_trig_thr(trig_thr),
    .i_sw_mask(sw_mask), .i_arm_mask(arm_mask), .i_pulse_mask(pulse_mask),
    .i_io_sel(io_sel), .i_io_cmd(io_cmd),
    .i_pulse_single(pulse_single), .i_pulse_en(pulse_en), .i_pulse_period(pulse_period),
    .i_pg_addr(o_pg_req_addr), .i_pg_optype(o_pg_optype),
    .i_ddr3_sys_rst(o_ddr3_sys_rst), .i_scaler_sel(scaler_sel),
    .i_vnum(i_vnum), .i_wvb_armed(i_wvb_armed), .i_disc_scaler(i_disc_scaler),
    .i_pg_status(pg_status)
  );

  io_ctrl_demux io_ctrl_demux_i (
    .clk(clk), .rst(rst), .i_io_sel(io_sel), .i_io_cmd(io_cmd),
    .o_adc_delay_ce(o_adc_delay_ce), .o_adc_delay_inc(o_adc_delay_inc),
    .o_adc_bitslip(o_adc_bitslip), .o_discr_bitslip(o_discr_bitslip)
  );

  pulser_timer pulser_timer_i (
    .clk(clk), .rst(rst), .i_period(pulse_period), .i_enable(pulse_en),
    .i_single(pulse_single), .o_pulser_trig(o_pulser_trig)
  );

  page_req_fsm page_req_fsm_i (
    .clk(clk), .rst(rst), .i_start(pg_start), .i_mem_enable(o_ddr3_sys_rst),
    .i_ack(i_pg_ack), .o_req(o_pg_req), .o_status(pg_status)
  );

endmodule

`default_nettype wire

// File: logic/page_req_fsm.sv
/* DDR3 page-transfer request: a level request held until the synchronized acknowledge
   Dropped at once when the DDR3 reset enable goes low */
`timescale 1ns/1ps
`default_nettype none

module page_req_fsm (
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  input  logic i_mem_enable,
  input  logic i_ack,
  output logic o_req,
  output logic o_status
);

  typedef enum logic {
    IDLE,
    REQUEST
  } state_t;

  state_t state;
  logic   ack_meta;
  logic   ack_sync;

  // Acknowledge comes from the DDR3 UI clock domain
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end else begin
      ack_meta <= i_ack;
      ack_sync <= ack_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (i_start && i_mem_enable && !ack_sync) state <= REQUEST;
        REQUEST: if (ack_sync || !i_mem_enable) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign o_req    = (state == REQUEST);
  assign o_status = o_req | ack_sync;

endmodule

`default_nettype wire

// File: logic/pulser_timer.sv
/* Periodic AFE pulser timer, combined with the single-shot bits
   A zero period holds the timer idle; a new period restarts the count */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module pulser_timer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [31:0]                 i_period,
  input  logic [`XDOM_N_PULSERS-1:0]  i_enable,
  input  logic [`XDOM_N_PULSERS-1:0]  i_single,
  output logic [`XDOM_N_PULSERS-1:0]  o_pulser_trig
);

  logic [31:0] count;
  logic [31:0] period_q;
  logic        tick;

  always_ff @(posedge clk) begin
    if (rst) begin
      count    <= '0;
      period_q <= '0;
      tick     <= 1'b0;
    end else begin
      period_q <= i_period;
      if (i_period == '0 || i_period != period_q) begin
        count <= '0;
        tick  <= 1'b0;
      end else if (count == i_period - 32'd1) begin
        count <= '0;
        tick  <= 1'b1;
      end else begin
        count <= count + 32'd1;
        tick  <= 1'b0;
      end
    end
  end

  assign o_pulser_trig = i_single | ({`XDOM_N_PULSERS{tick}} & i_enable);

endmodule

`default_nettype wire

// File: logic/io_ctrl_demux.sv
/* Steers the IO-alignment command strobe onto the selected channel's ADC lanes
   and discriminator bitslip, one register stage before the outputs */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module io_ctrl_demux (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`XDOM_SEL_W-1:0]        i_io_sel,
  input  xdom_pkg::io_cmd_t             i_io_cmd,
  output logic [2*`XDOM_N_CHANNELS-1:0] o_adc_delay_ce,
  output logic [2*`XDOM_N_CHANNELS-1:0] o_adc_delay_inc,
  output logic [2*`XDOM_N_CHANNELS-1:0] o_adc_bitslip,
  output logic [`XDOM_N_CHANNELS-1:0]   o_discr_bitslip
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_adc_delay_ce  <= '0;
      o_adc_delay_inc <= '0;
      o_adc_bitslip   <= '0;
      o_discr_bitslip <= '0;
    end else begin
      // Lane 0 on the even bit, lane 1 on the odd bit
      for (int ch = 0; ch < `XDOM_N_CHANNELS; ch++) begin
        if (i_io_sel == ch) begin
          o_adc_delay_ce[2*ch +: 2]  <= {i_io_cmd.l1_ce, i_io_cmd.l0_ce};
          o_adc_delay_inc[2*ch +: 2] <= {i_io_cmd.l1_inc, i_io_cmd.l0_inc};
          o_adc_bitslip[2*ch +: 2]   <= {i_io_cmd.l1_bitslip, i_io_cmd.l0_bitslip};
          o_discr_bitslip[ch]        <= i_io_cmd.disc_bitslip;
        end else begin
          o_adc_delay_ce[2*ch +: 2]  <= 2'b00;
          o_adc_delay_inc[2*ch +: 2] <= 2'b00;
          o_adc_bitslip[2*ch +: 2]   <= 2'b00;
          o_discr_bitslip[ch]        <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/xdom_rd_mux.sv
/* Read-data selection for the register map, with the registered scaler channel mux
   Unmapped addresses read zero */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module xdom_rd_mux (
  input  logic                                          clk,
  input  logic                                          rst,
  reg_bus_if.slave                                      bus,
  input  xdom_pkg::trig_conf_t                          i_trig_conf,
  input  logic [11:0]                                   i_trig_thr,
  input  logic [`XDOM_N_CHANNELS-1:0]                   i_sw_mask,
  input  logic [`XDOM_N_CHANNELS-1:0]                   i_arm_mask,
  input  logic [`XDOM_N_CHANNELS-1:0]                   i_pulse_mask,
  input  logic [`XDOM_SEL_W-1:0]                        i_io_sel,
  input  xdom_pkg::io_cmd_t                             i_io_cmd,
  input  logic [`XDOM_N_PULSERS-1:0]                    i_pulse_single,
  input  logic [`XDOM_N_PULSERS-1:0]                    i_pulse_en,
  input  logic [31:0]                                   i_pulse_period,
  input  logic [`XDOM_PG_ADR_W-1:0]                     i_pg_addr,
  input  logic                                          i_pg_optype,
  input  logic                                          i_ddr3_sys_rst,
  input  logic [`XDOM_SEL_W-1:0]                        i_scaler_sel,
  input  logic [`XDOM_DATA_W-1:0]                       i_vnum,
  input  logic [`XDOM_N_CHANNELS-1:0]                   i_wvb_armed,
  input  logic [`XDOM_N_CHANNELS-1:0][`XDOM_SCALER_W-1:0] i_disc_scaler,
  input  logic                                          i_pg_status
);

  logic [`XDOM_SCALER_W-1:0] scaler_q;
  xdom_pkg::reg_word_u       rd_word;

  // Selects past the last channel read as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      scaler_q <= '0;
    end else if (i_scaler_sel < `XDOM_N_CHANNELS) begin
      scaler_q <= i_disc_scaler[i_scaler_sel];
    end else begin
      scaler_q <= '0;
    end
  end

  always_comb begin
    rd_word.raw = '0;
    case (bus.adr)
      `XDOM_ADR_VNUM: rd_word.raw = i_vnum;
      `XDOM_ADR_TRIG_CONF: rd_word.trig_conf = i_trig_conf;
      `XDOM_ADR_TRIG_THR: rd_word.raw = 16'(i_trig_thr);
      `XDOM_ADR_SW_MASK_HI: rd_word.raw = 16'(i_sw_mask[`XDOM_N_CHANNELS-1:16]);
      `XDOM_ADR_SW_MASK_LO: rd_word.raw = i_sw_mask[15:0];
      `XDOM_ADR_ARM_MASK_HI: rd_word.raw = 16'(i_arm_mask[`XDOM_N_CHANNELS-1:16]);
      `XDOM_ADR_ARM_MASK_LO: rd_word.raw = i_arm_mask[15:0];
      `XDOM_ADR_ARMED_HI: rd_word.raw = 16'(i_wvb_armed[`XDOM_N_CHANNELS-1:16]);
      `XDOM_ADR_ARMED_LO: rd_word.raw = i_wvb_armed[15:0];
      `XDOM_ADR_IO_SEL: rd_word.raw = 16'(i_io_sel);
      `XDOM_ADR_IO_CMD: rd_word.io_cmd = i_io_cmd;
      `XDOM_ADR_PULSE_MASK_HI: rd_word.raw = 16'(i_pulse_mask[`XDOM_N_CHANNELS-1:16]);
      `XDOM_ADR_PULSE_MASK_LO: rd_word.raw = i_pulse_mask[15:0];
      `XDOM_ADR_PULSE_SINGLE: rd_word.raw = 16'(i_pulse_single);
      `XDOM_ADR_PG_ADR_HI: rd_word.raw = 16'(i_pg_addr[`XDOM_PG_ADR_W-1:16]);
      `XDOM_ADR_PG_ADR_LO: rd_word.raw = i_pg_addr[15:0];
      `XDOM_ADR_PG_OPTYPE: rd_word.raw = 16'(i_pg_optype);
      `XDOM_ADR_PG_CMD: rd_word.raw = 16'(i_pg_status);
      `XDOM_ADR_DDR3_RST: rd_word.raw = 16'(i_ddr3_sys_rst);
      `XDOM_ADR_SCALER_SEL: rd_word.raw = 16'(i_scaler_sel);
      `XDOM_ADR_SCALER_HI: rd_word.raw = scaler_q[31:16];
      `XDOM_ADR_SCALER_LO: rd_word.raw = scaler_q[15:0];
      `XDOM_ADR_PULSE_PER_HI: rd_word.raw = i_pulse_period[31:16];
      `XDOM_ADR_PULSE_PER_LO: rd_word.raw = i_pulse_period[15:0];
      `XDOM_ADR_PULSE_EN: rd_word.raw = 16'(i_pulse_en);
      default: ;
    endcase
  end

  assign bus.rd_data = rd_word.raw;

endmodule

`default_nettype wire

// File: logic/xdom_regs.sv
/* Write decode for the register map: configuration registers and one-cycle command
   strobes for triggering, arming, IO alignment, the pulser and page requests */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

module xdom_regs (
  input  logic                         clk,
  input  logic                         rst,
  reg_bus_if.slave                     bus,
  output xdom_pkg::trig_conf_t         o_trig_conf,
  output logic [11:0]                  o_trig_thr,
  output logic [`XDOM_N_CHANNELS-1:0]  o_trig_run,
  output logic [`XDOM_N_CHANNELS-1:0]  o_wvb_arm,
  output logic [`XDOM_N_CHANNELS-1:0]  o_sw_mask,
  output logic [`XDOM_N_CHANNELS-1:0]  o_arm_mask,
  output logic [`XDOM_N_CHANNELS-1:0]  o_pulse_mask,
  output logic [`XDOM_SEL_W-1:0]       o_io_sel,
  output xdom_pkg::io_cmd_t            o_io_cmd,
  output logic [`XDOM_N_PULSERS-1:0]   o_pulse_single,
  output logic [`XDOM_N_PULSERS-1:0]   o_pulse_en,
  output logic [31:0]                  o_pulse_period,
  output logic                         o_pg_start,
  output logic [`XDOM_PG_ADR_W-1:0]    o_pg_addr,
  output logic                         o_pg_optype,
  output logic                         o_ddr3_sys_rst,
  output logic [`XDOM_SEL_W-1:0]       o_scaler_sel
);

  xdom_pkg::reg_word_u  wr_word;
  xdom_pkg::trig_conf_t conf_word;
  xdom_pkg::io_cmd_t    cmd_word;

  // Same write word, two decodes; unused bits dropped
  always_comb begin
    wr_word.raw = bus.wr_data;
    conf_word = wr_word.trig_conf;
    conf_word.unused = '0;
    cmd_word = wr_word.io_cmd;
    cmd_word.rsvd_hi = '0;
    cmd_word.rsvd_7 = 1'b0;
    cmd_word.rsvd_3 = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Register writes
  always_ff @(posedge clk) begin
    if (rst) begin
      o_trig_conf    <= '0;
      o_trig_thr     <= '0;
      o_trig_run     <= '0;
      o_wvb_arm      <= '0;
      o_sw_mask      <= '0;
      o_arm_mask     <= '0;
      o_pulse_mask   <= '0;
      o_io_sel       <= '0;
      o_io_cmd       <= '0;
      o_pulse_single <= '0;
      o_pulse_en     <= '0;
      o_pulse_period <= '0;
      o_pg_start     <= 1'b0;
      o_pg_addr      <= '0;
      o_pg_optype    <= 1'b0;
      o_ddr3_sys_rst <= 1'b0;
      o_scaler_sel   <= '0;
    end else begin
      // Strobes live for one cycle only
      o_trig_run     <= '0;
      o_wvb_arm      <= '0;
      o_io_cmd       <= '0;
      o_pulse_single <= '0;
      o_pg_start     <= 1'b0;

      if (bus.wr) begin
        case (bus.adr)
          `XDOM_ADR_TRIG_CONF: o_trig_conf <= conf_word;
          `XDOM_ADR_TRIG_THR: o_trig_thr <= bus.wr_data[11:0];
          `XDOM_ADR_SW_MASK_HI:
            o_sw_mask[`XDOM_N_CHANNELS-1:16] <= bus.wr_data[`XDOM_N_CHANNELS-17:0];
          `XDOM_ADR_SW_MASK_LO: o_sw_mask[15:0] <= bus.wr_data;
          `XDOM_ADR_ARM_MASK_HI:
            o_arm_mask[`XDOM_N_CHANNELS-1:16] <= bus.wr_data[`XDOM_N_CHANNELS-17:0];
          `XDOM_ADR_ARM_MASK_LO: o_arm_mask[15:0] <= bus.wr_data;
          `XDOM_ADR_TRIG_CMD: begin
            if (bus.wr_data[0]) o_trig_run <= o_sw_mask;
            if (bus.wr_data[1]) o_wvb_arm <= o_arm_mask;
          end
          `XDOM_ADR_IO_SEL: o_io_sel <= bus.wr_data[`XDOM_SEL_W-1:0];
          `XDOM_ADR_IO_CMD: o_io_cmd <= cmd_word;
          `XDOM_ADR_PULSE_MASK_HI:
            o_pulse_mask[`XDOM_N_CHANNELS-1:16] <= bus.wr_data[`XDOM_N_CHANNELS-17:0];
          `XDOM_ADR_PULSE_MASK_LO: o_pulse_mask[15:0] <= bus.wr_data;
          // Single shot also fires the channels in the pulser mask
          `XDOM_ADR_PULSE_SINGLE: begin
            o_pulse_single <= bus.wr_data[`XDOM_N_PULSERS-1:0];
            o_trig_run     <= o_pulse_mask;
          end
          `XDOM_ADR_PG_ADR_HI:
            o_pg_addr[`XDOM_PG_ADR_W-1:16] <= bus.wr_data[`XDOM_PG_ADR_W-17:0];
          `XDOM_ADR_PG_ADR_LO: o_pg_addr[15:0] <= bus.wr_data;
          `XDOM_ADR_PG_OPTYPE: o_pg_optype <= bus.wr_data[0];
          `XDOM_ADR_PG_CMD: o_pg_start <= bus.wr_data[0];
          `XDOM_ADR_DDR3_RST: o_ddr3_sys_rst <= bus.wr_data[0];
          `XDOM_ADR_SCALER_SEL: o_scaler_sel <= bus.wr_data[`XDOM_SEL_W-1:0];
          `XDOM_ADR_PULSE_PER_HI: o_pulse_period[31:16] <= bus.wr_data;
          `XDOM_ADR_PULSE_PER_LO: o_pulse_period[15:0] <= bus.wr_data;
          `XDOM_ADR_PULSE_EN: o_pulse_en <= bus.wr_data[`XDOM_N_PULSERS-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: common/reg_bus_if.sv
/* Register bus between the top-level ports and the register and readback blocks
   Writes land on the clock edge with wr high, reads are combinational from adr */
`timescale 1ns/1ps
`default_nettype none

`include "xdom_settings.svh"

interface reg_bus_if;

  logic [`XDOM_ADR_W-1:0]  adr;
  logic                    wr;
  logic [`XDOM_DATA_W-1:0] wr_data;
  logic [`XDOM_DATA_W-1:0] rd_data;

  modport master (
    output adr,
    output wr,
    output wr_data,
    input  rd_data
  );

  modport slave (
    input  adr,
    input  wr,
    input  wr_data,
    output rd_data
  );

endinterface

`default_nettype wire

// File: common/xdom_pkg.sv
/* Register word layouts, shared by the write decode and the readback mux */
`default_nettype none

package xdom_pkg;

  // Trigger configuration, equal comparison in bit 0
  typedef struct packed {
    logic [8:0] unused;
    logic       ext_en;
    logic       thr_en;
    logic       disc_en;
    logic       disc_pol;
    logic       lt;
    logic       gt;
    logic       et;
  } trig_conf_t;

  // IO alignment command, lane 0 in the low nibble, lane 1 above it
  typedef struct packed {
    logic [6:0] rsvd_hi;
    logic       disc_bitslip;
    logic       rsvd_7;
    logic       l1_bitslip;
    logic       l1_ce;
    logic       l1_inc;
    logic       rsvd_3;
    logic       l0_bitslip;
    logic       l0_ce;
    logic       l0_inc;
  } io_cmd_t;

  // One bus word, viewed per the address it belongs to
  typedef union packed {
    logic [15:0] raw;
    trig_conf_t  trig_conf;
    io_cmd_t     io_cmd;
  } reg_word_u;

endpackage

`default_nettype wire

// File: common/xdom_settings.svh
/* Channel count, field widths and the register map of the front-end register block
   Included by every RTL file and the testbench */
`ifndef XDOM_SETTINGS_SVH
`define XDOM_SETTINGS_SVH

`define XDOM_N_CHANNELS 24
`define XDOM_ADR_W 12
`define XDOM_DATA_W 16
`define XDOM_SCALER_W 32
`define XDOM_SEL_W 5
`define XDOM_PG_ADR_W 28
`define XDOM_N_PULSERS 6

// Trigger and arming
`define XDOM_ADR_VNUM 12'hfff
`define XDOM_ADR_TRIG_CONF 12'hbfe
`define XDOM_ADR_TRIG_THR 12'hbfd
`define XDOM_ADR_SW_MASK_HI 12'hbfc
`define XDOM_ADR_SW_MASK_LO 12'hbfb
`define XDOM_ADR_ARM_MASK_HI 12'hbfa
`define XDOM_ADR_ARM_MASK_LO 12'hbf9
`define XDOM_ADR_TRIG_CMD 12'hbf8
`define XDOM_ADR_ARMED_HI 12'hbf6
`define XDOM_ADR_ARMED_LO 12'hbf5

// IO alignment
`define XDOM_ADR_IO_SEL 12'hbe6
`define XDOM_ADR_IO_CMD 12'hbe5

// AFE pulser and DDR3 pages
`define XDOM_ADR_PULSE_MASK_HI 12'hbd0
`define XDOM_ADR_PULSE_MASK_LO 12'hbcf
`define XDOM_ADR_PULSE_SINGLE 12'hbce
`define XDOM_ADR_PG_ADR_HI 12'hbcd
`define XDOM_ADR_PG_ADR_LO 12'hbcc
`define XDOM_ADR_PG_OPTYPE 12'hbcb
`define XDOM_ADR_PG_CMD 12'hbca
`define XDOM_ADR_DDR3_RST 12'hbc9

// Scalers and periodic pulser
`define XDOM_ADR_SCALER_SEL 12'hbb8
`define XDOM_ADR_SCALER_HI 12'hbb7
`define XDOM_ADR_SCALER_LO 12'hbb6
`define XDOM_ADR_PULSE_PER_HI 12'hbb3
`define XDOM_ADR_PULSE_PER_LO 12'hbb2
`define XDOM_ADR_PULSE_EN 12'hbb1

`endif
